//--- files.f
video_pkg.sv
color_tables.sv
subcarrier_nco.sv
chroma_modulator.sv
composite_mixer.sv
video_encoder_top.sv
tb_video_encoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_video_encoder \
        -f files.f -o sim_video_encoder

./obj_dir/sim_video_encoder | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
        echo "simulation reported failure"
        exit 1
fi

echo "simulation finished without failure"

//--- tb_video_encoder.sv
`default_nettype none

module tb_video_encoder import video_pkg::*; ();

        timeunit 1ns;
        timeprecision 100ps;

        localparam int CLK_PERIOD   = 20;
        localparam int RESET_CYCLES = 4;
        localparam int N_DEFAULT    = 200;
        localparam int N_MIRROR     = 24;
        localparam int N_BLANK      = 30;
        localparam int N_CFG        = 80;
        localparam int N_SAT        = 40;
        // every drive, config load and drain cycle of the run
        localparam int TOTAL_CYCLES = RESET_CYCLES + N_DEFAULT + N_MIRROR + N_BLANK
                                      + N_CFG + 3 + N_SAT + 2 + 4;

        typedef struct packed {
                logic                valid;
                logic [2:0]          test;
                logic [SAMPLE_W-1:0] level;
        } expect_t;

        logic                clk_col16x = 1'b0;
        logic                arst_n_i;
        color_idx_t          index_i;
        logic                blank_i;
        logic                sync_i;
        logic                line_start_i;
        logic                use_cfg_i;
        color_cfg_t          cfg_i;
        logic [SAMPLE_W-1:0] composite_o;

        logic [2:0]          test_no;
        logic [15:0]         seen_idx;
        int                  err_value = 0;
        int                  err_other = 0;
        int                  reset_edges = 0;

        logic [PHASE_W-1:0]  carrier_m;        // model copy of the subcarrier
        logic                odd_m;
        int                  cfg_settle;
        color_cfg_t          cfg_last;
        expect_t             exp_q[$];         // 3 samples in flight

        always #(CLK_PERIOD / 2) clk_col16x = ~clk_col16x;

        video_encoder_top DUT (
                .clk_col16x   (clk_col16x),
                .arst_n_i     (arst_n_i),
                .index_i      (index_i),
                .blank_i      (blank_i),
                .sync_i       (sync_i),
                .line_start_i (line_start_i),
                .use_cfg_i    (use_cfg_i),
                .cfg_i        (cfg_i),
                .composite_o  (composite_o)
        );

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic string test_name(input logic [2:0] t);
                case (t)
                        3'd0:    return "reset";
                        3'd1:    return "default_palette";
                        3'd2:    return "odd_line_mirror";
                        3'd3:    return "blank_sync";
                        3'd4:    return "config_tables";
                        3'd5:    return "saturation";
                        default: return "unknown";
                endcase
        endfunction

        // luma plus scaled sine at the hue angle, clamped, then blank/sync override
        function automatic logic [SAMPLE_W-1:0] expected_level(
                input color_idx_t         idx,
                input logic               blank,
                input logic               sync,
                input logic               use_cfg,
                input color_cfg_t         cfg,
                input logic               odd,
                input logic [PHASE_W-1:0] carrier);
                int                 luma;
                logic [AMP_W-1:0]   amp;
                logic [PHASE_W-1:0] hue;
                logic [PHASE_W-1:0] angle;
                int                 chroma;
                int                 sum;
                luma = use_cfg ? int'(cfg.luma[idx]) : int'(DEFAULT_LUMA[idx]);
                amp  = use_cfg ? cfg.amp[idx] : DEFAULT_AMP[idx];
                hue  = use_cfg ? cfg.phase[idx] : DEFAULT_PHASE[idx];
                if (odd) begin
                        hue = 8'(256 - int'(hue));      // PAL line alternation
                end
                angle  = hue + carrier;
                chroma = SINE_LUT[angle[7:4]];
                chroma = (amp == AMP_NONE) ? 0 : (chroma >>> amp);
                sum    = luma + chroma;
                if (sum < 0) sum = 0;
                if (sum > 127) sum = 127;
                if (sync) return SYNC_LEVEL;
                if (blank) return BLANK_LEVEL;
                return 7'(sum);
        endfunction

        task automatic drive_cycle(input logic [2:0] test, input color_idx_t idx,
                                   input logic blank, input logic sync, input logic ls);
                @(posedge clk_col16x);
                test_no      <= test;
                index_i      <= idx;
                blank_i      <= blank;
                sync_i       <= sync;
                line_start_i <= ls;
        endtask

        task automatic load_config(input logic [2:0] test, input color_cfg_t cfg,
                                   input logic use_cfg);
                @(posedge clk_col16x);
                test_no   <= test;
                cfg_i     <= cfg;
                use_cfg_i <= use_cfg;
        endtask

        // reference model sampling the inputs the DUT captures at this edge
        always @(posedge clk_col16x) begin
                expect_t e;
                if (!arst_n_i) begin
                        carrier_m  = '0;
                        odd_m      = 1'b0;
                        cfg_settle = 0;
                        cfg_last   = cfg_i;
                        exp_q.delete();
                        e.valid = 1'b1;
                        e.test  = 3'd0;
                        e.level = '0;
                        exp_q.push_back(e);     // cleared pipeline drains zeros
                        exp_q.push_back(e);
                        reset_edges++;
                end else begin
                        carrier_m = carrier_m + CARRIER_STEP;
                        if (cfg_i != cfg_last) cfg_settle = 2;
                        else if (cfg_settle > 0) cfg_settle--;
                        cfg_last = cfg_i;
                        e.valid  = (cfg_settle == 0);   // config still crossing over
                        e.test   = test_no;
                        e.level  = expected_level(index_i, blank_i, sync_i, use_cfg_i,
                                                  cfg_i, odd_m, carrier_m);
                        exp_q.push_back(e);
                        if (exp_q.size() > 3) void'(exp_q.pop_front());
                        if (line_start_i) odd_m = ~odd_m;
                end
        end

        always @(negedge clk_col16x) begin
                if (!arst_n_i) begin
                        if (reset_edges > 0) begin
                                assert (composite_o == '0) else begin
                                        err_value++;
                                        $display("ERR %s expected %0d actual %0d",
                                                 test_name(3'd0), 0, composite_o);
                                end
                        end
                end else if (exp_q.size() == 3 && exp_q[0].valid) begin
                        assert (composite_o == exp_q[0].level) else begin
                                err_value++;
                                $display("ERR %s expected %0d actual %0d",
                                         test_name(exp_q[0].test), exp_q[0].level,
                                         composite_o);
                        end
                end
        end

        initial begin
                logic [31:0] lcg_state;
                color_cfg_t  cfg;
                arst_n_i     = 1'b0;
                index_i      = COL_BLACK;
                blank_i      = 1'b0;
                sync_i       = 1'b0;
                line_start_i = 1'b0;
                use_cfg_i    = 1'b0;
                cfg_i        = '0;
                test_no      = 3'd0;
                seen_idx     = '0;
                lcg_state    = 32'hf4cf_65f8;
                repeat (RESET_CYCLES) @(posedge clk_col16x);
                arst_n_i <= 1'b1;

                for (int i = 0; i < N_DEFAULT; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        drive_cycle(3'd1, color_idx_t'(lcg_state[31:28]), 1'b0, 1'b0, 1'b0);
                        seen_idx[lcg_state[31:28]] = 1'b1;
                end
                assert (seen_idx == 16'hffff) else begin
                        err_other++;
                        $display("not every palette index was driven in the default test");
                end

                // first pulse flips to an odd line and the second one back to even
                drive_cycle(3'd2, COL_RED, 1'b0, 1'b0, 1'b1);
                repeat (N_MIRROR / 2 - 1) drive_cycle(3'd2, COL_RED, 1'b0, 1'b0, 1'b0);
                drive_cycle(3'd2, COL_RED, 1'b0, 1'b0, 1'b1);
                repeat (N_MIRROR / 2 - 1) drive_cycle(3'd2, COL_RED, 1'b0, 1'b0, 1'b0);

                for (int i = 0; i < N_BLANK; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        drive_cycle(3'd3, color_idx_t'(lcg_state[31:28]),
                                    (i % 3) != 1, (i % 3) != 0, 1'b0);
                end

                for (int c = 0; c < NUM_COLORS; c++) begin
                        cfg.luma[c]  = 6'(63 - int'(DEFAULT_LUMA[c]));
                        cfg.amp[c]   = (c % 4 == 3) ? AMP_NONE : 3'(c % 3);
                        cfg.phase[c] = DEFAULT_PHASE[c] + 8'd48;
                end
                load_config(3'd4, cfg, 1'b1);
                repeat (2) drive_cycle(3'd4, COL_BLACK, 1'b0, 1'b0, 1'b0);
                for (int i = 0; i < N_CFG; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        drive_cycle(3'd4, (i < 16) ? color_idx_t'(4'(i))
                                                   : color_idx_t'(lcg_state[31:28]),
                                    1'b0, 1'b0, 1'b0);
                end

                for (int c = 0; c < NUM_COLORS; c++) begin
                        cfg.luma[c] = '1;       // brightest luma, strongest chroma
                        cfg.amp[c]  = '0;
                end
                load_config(3'd5, cfg, 1'b1);
                for (int i = 0; i < N_SAT / 2; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        drive_cycle(3'd5, color_idx_t'(lcg_state[31:28]), 1'b0, 1'b0, 1'b0);
                end
                for (int c = 0; c < NUM_COLORS; c++) cfg.luma[c] = '0;
                load_config(3'd5, cfg, 1'b1);
                for (int i = 0; i < N_SAT / 2; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        drive_cycle(3'd5, color_idx_t'(lcg_state[31:28]), 1'b0, 1'b0, 1'b0);
                end

                repeat (4) @(posedge clk_col16x);       // let the pipeline drain
                $display("errors: value mismatches %0d, other %0d", err_value, err_other);
                if (err_value == 0 && err_other == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

        initial begin
                #(CLK_PERIOD * (TOTAL_CYCLES + 100));
                $display("watchdog expired before the tests completed");
                $display("*** FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

//--- video_encoder_top.sv
`default_nettype none

module video_encoder_top import video_pkg::*; (
        input  logic                clk_col16x,
        input  logic                arst_n_i,
        input  color_idx_t          index_i,
        input  logic                blank_i,
        input  logic                sync_i,
        input  logic                line_start_i,
        input  logic                use_cfg_i,
        input  color_cfg_t          cfg_i,
        output logic [SAMPLE_W-1:0] composite_o
);

        color_attr_t                attr_tab;       // table lookup stage
        color_attr_t                attr_mod;       // aligned with chroma
        logic [PHASE_W-1:0]         carrier_phase;
        logic                       odd_line;
        logic signed [SAMPLE_W-1:0] chroma;

        color_tables u_color_tables (
                .clk_col16x (clk_col16x),
                .arst_n_i   (arst_n_i),
                .index_i    (index_i),
                .blank_i    (blank_i),
                .sync_i     (sync_i),
                .odd_line_i (odd_line),
                .use_cfg_i  (use_cfg_i),
                .cfg_i      (cfg_i),
                .attr_o     (attr_tab)
        );

        subcarrier_nco u_subcarrier_nco (
                .clk_col16x   (clk_col16x),
                .arst_n_i     (arst_n_i),
                .line_start_i (line_start_i),
                .phase_o      (carrier_phase),
                .odd_line_o   (odd_line)
        );

        chroma_modulator u_chroma_modulator (
                .clk_col16x (clk_col16x),
                .arst_n_i   (arst_n_i),
                .attr_i     (attr_tab),
                .carrier_i  (carrier_phase),
                .chroma_o   (chroma),
                .attr_o     (attr_mod)
        );

        composite_mixer u_composite_mixer (
                .clk_col16x  (clk_col16x),
                .arst_n_i    (arst_n_i),
                .chroma_i    (chroma),
                .attr_i      (attr_mod),
                .composite_o (composite_o)
        );

endmodule

`default_nettype wire

//--- composite_mixer.sv
`default_nettype none

module composite_mixer import video_pkg::*; (
        input  logic                       clk_col16x,
        input  logic                       arst_n_i,
        input  logic signed [SAMPLE_W-1:0] chroma_i,
        input  color_attr_t                attr_i,
        output logic [SAMPLE_W-1:0]        composite_o
);

        logic signed [SAMPLE_W+1:0] sum;        // two guard bits for sign and overflow
        logic [SAMPLE_W-1:0]        level_d;
        logic [SAMPLE_W-1:0]        level_q;

        always_comb begin
                sum = $signed((SAMPLE_W+2)'(attr_i.luma)) + chroma_i;

                if (sum[SAMPLE_W+1]) begin
                        level_d = '0;                   // clamp below black
                end else if (sum[SAMPLE_W]) begin
                        level_d = SAMPLE_MAX;
                end else begin
                        level_d = sum[SAMPLE_W-1:0];
                end

                // sync wins over blanking
                if (attr_i.vid_ctl[VID_SYNC_BIT]) begin
                        level_d = SYNC_LEVEL;
                end else if (attr_i.vid_ctl[VID_BLANK_BIT]) begin
                        level_d = BLANK_LEVEL;
                end
        end

        always_ff @(posedge clk_col16x or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        level_q <= '0;
                end else begin
                        level_q <= level_d;
                end
        end

        assign composite_o = level_q;

endmodule

`default_nettype wire

//--- chroma_modulator.sv
`default_nettype none

module chroma_modulator import video_pkg::*; (
        input  logic                       clk_col16x,
        input  logic                       arst_n_i,
        input  color_attr_t                attr_i,
        input  logic [PHASE_W-1:0]         carrier_i,
        output logic signed [SAMPLE_W-1:0] chroma_o,
        output color_attr_t                attr_o
);

        logic [PHASE_W-1:0]         phase_sum;
        logic signed [SINE_W-1:0]   sine_val;
        logic signed [SINE_W-1:0]   sine_scaled;
        logic signed [SAMPLE_W-1:0] chroma_d;
        logic signed [SAMPLE_W-1:0] chroma_q;
        color_attr_t                attr_q;

        always_comb begin
                phase_sum   = attr_i.phase + carrier_i;    // hue offset on the carrier
                sine_val    = SINE_LUT[phase_sum[PHASE_W-1 -: SINE_IDX_W]];
                sine_scaled = sine_val >>> attr_i.amp;     // amp is a shift count

                // grey shades and blanked or sync samples carry no colour
                if (attr_i.amp == AMP_NONE || attr_i.vid_ctl != '0) begin
                        chroma_d = '0;
                end else begin
                        chroma_d = SAMPLE_W'(sine_scaled);
                end
        end

        // attribute follows along so luma lines up with its chroma
        always_ff @(posedge clk_col16x or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        chroma_q <= '0;
                        attr_q   <= '0;
                end else begin
                        chroma_q <= chroma_d;
                        attr_q   <= attr_i;
                end
        end

        assign chroma_o = chroma_q;
        assign attr_o   = attr_q;

endmodule

`default_nettype wire

//--- subcarrier_nco.sv
`default_nettype none

module subcarrier_nco import video_pkg::*; (
        input  logic               clk_col16x,
        input  logic               arst_n_i,
        input  logic               line_start_i,
        output logic [PHASE_W-1:0] phase_o,
        output logic               odd_line_o
);

        logic [PHASE_W-1:0] phase_q;
        logic               odd_q;

        // one full turn every 16 cycles of the 16x clock
        always_ff @(posedge clk_col16x or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        phase_q <= '0;
                        odd_q   <= 1'b0;
                end else begin
                        phase_q <= phase_q + CARRIER_STEP;      // wraps mod 256
                        if (line_start_i) begin
                                odd_q <= ~odd_q;
                        end
                end
        end

        assign phase_o    = phase_q;
        assign odd_line_o = odd_q;

endmodule

`default_nettype wire

//--- color_tables.sv
`default_nettype none

module color_tables import video_pkg::*; (
        input  logic        clk_col16x,
        input  logic        arst_n_i,
        input  color_idx_t  index_i,
        input  logic        blank_i,
        input  logic        sync_i,
        input  logic        odd_line_i,
        input  logic        use_cfg_i,
        input  color_cfg_t  cfg_i,
        output color_attr_t attr_o
);

        color_cfg_t         cfg_meta;   // first stage out of the dot-clock domain
        color_cfg_t         cfg_sync;
        logic [LUMA_W-1:0]  luma_sel;
        logic [AMP_W-1:0]   amp_sel;
        logic [PHASE_W-1:0] phase_even;
        logic [PHASE_W-1:0] phase_odd;
        color_attr_t        attr_d;
        color_attr_t        attr_q;

        // two flop crossing of the quasi-static config
        always_ff @(posedge clk_col16x) begin
                cfg_meta <= cfg_i;
                cfg_sync <= cfg_meta;
        end

        // run time pick between configured and built-in palette
        always_comb begin
                if (use_cfg_i) begin
                        luma_sel   = cfg_sync.luma[index_i];
                        amp_sel    = cfg_sync.amp[index_i];
                        phase_even = cfg_sync.phase[index_i];
                end else begin
                        luma_sel   = DEFAULT_LUMA[index_i];
                        amp_sel    = DEFAULT_AMP[index_i];
                        phase_even = DEFAULT_PHASE[index_i];
                end
        end

        assign phase_odd = '0 - phase_even;     // 256 minus phase mod 256

        always_comb begin
                attr_d.luma    = luma_sel;
                attr_d.amp     = amp_sel;
                // PAL style alternation of the hue
                attr_d.phase   = odd_line_i ? phase_odd : phase_even;
                attr_d.vid_ctl = '0;
                attr_d.vid_ctl[VID_SYNC_BIT]  = sync_i;
                attr_d.vid_ctl[VID_BLANK_BIT] = blank_i;
        end

        always_ff @(posedge clk_col16x or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        attr_q <= '0;
                end else begin
                        attr_q <= attr_d;       // stage 1 of 3
                end
        end

        assign attr_o = attr_q;

endmodule

`default_nettype wire

//--- video_pkg.sv
`default_nettype none

package video_pkg;

        localparam int LUMA_W     = 6;
        localparam int AMP_W      = 3;
        localparam int PHASE_W    = 8;
        localparam int SAMPLE_W   = 7;
        localparam int NUM_COLORS = 16;
        localparam int SINE_W     = 6;
        localparam int SINE_IDX_W = 4;          // upper phase bits into the sine table

        // palette order of the chip
        typedef enum logic [3:0] {
                COL_BLACK,  COL_WHITE,     COL_RED,         COL_CYAN,
                COL_PURPLE, COL_GREEN,     COL_BLUE,        COL_YELLOW,
                COL_ORANGE, COL_BROWN,     COL_PINK,        COL_DARK_GREY,
                COL_GREY,   COL_LIGHT_GREEN, COL_LIGHT_BLUE, COL_LIGHT_GREY
        } color_idx_t;

        localparam logic [AMP_W-1:0]    AMP_NONE     = 3'b111;  // no modulation
        localparam logic [PHASE_W-1:0]  CARRIER_STEP = 8'd16;   // 1/16 turn per cycle
        localparam logic [SAMPLE_W-1:0] BLANK_LEVEL  = 7'd19;
        localparam logic [SAMPLE_W-1:0] SYNC_LEVEL   = 7'd0;
        localparam logic [SAMPLE_W-1:0] SAMPLE_MAX   = 7'd127;

        // bit positions inside vid_ctl
        localparam int VID_BLANK_BIT = 0;
        localparam int VID_SYNC_BIT  = 1;

        localparam logic [LUMA_W-1:0] DEFAULT_LUMA [NUM_COLORS] = '{
                6'd19, 6'd59, 6'd31, 6'd44,     // black white red cyan
                6'd34, 6'd39, 6'd28, 6'd50,     // purple green blue yellow
                6'd34, 6'd28, 6'd39, 6'd31,     // orange brown pink dark grey
                6'd38, 6'd50, 6'd38, 6'd44      // grey lt green lt blue lt grey
        };

        // 000 is the strongest and each step halves the chroma
        localparam logic [AMP_W-1:0] DEFAULT_AMP [NUM_COLORS] = '{
                3'b111, 3'b111, 3'b010, 3'b010,
                3'b001, 3'b001, 3'b010, 3'b000,
                3'b000, 3'b010, 3'b010, 3'b111,
                3'b111, 3'b010, 3'b010, 3'b111
        };

        // even line hue in 1/256 turn units
        localparam logic [PHASE_W-1:0] DEFAULT_PHASE [NUM_COLORS] = '{
                8'd0,   8'd0,   8'd80,  8'd208,
                8'd32,  8'd160, 8'd0,   8'd128,
                8'd96,  8'd112, 8'd80,  8'd0,
                8'd0,   8'd160, 8'd0,   8'd0
        };

        // 31 * sin(2*pi*k/16)
        localparam logic signed [SINE_W-1:0] SINE_LUT [2**SINE_IDX_W] = '{
                6'sd0,   6'sd12,  6'sd22,  6'sd29,
                6'sd31,  6'sd29,  6'sd22,  6'sd12,
                6'sd0,  -6'sd12, -6'sd22, -6'sd29,
               -6'sd31, -6'sd29, -6'sd22, -6'sd12
        };

        typedef struct packed {
                logic [NUM_COLORS-1:0][LUMA_W-1:0]  luma;
                logic [NUM_COLORS-1:0][AMP_W-1:0]   amp;
                logic [NUM_COLORS-1:0][PHASE_W-1:0] phase;
        } color_cfg_t;

        typedef struct packed {
                logic [LUMA_W-1:0]  luma;
                logic [AMP_W-1:0]   amp;
                logic [PHASE_W-1:0] phase;
                logic [1:0]         vid_ctl;    // sync, blank
        } color_attr_t;

endpackage

`default_nettype wire
